// ==== src/riscv_isa_pkg.sv ====
// ----------------------------
// rv32i control-flow encoding
// major opcodes, field positions and immediate widths
// ----------------------------
package riscv_isa_pkg;

    // ----------------------------
    // field positions
    // ----------------------------
    localparam int unsigned OPCODE_W = 7;
    localparam int unsigned RD_LSB   = 7;
    localparam int unsigned RS1_LSB  = 15;

    // b-type offset is 13 bits with implicit zero lsb
    localparam int unsigned B_IMM_W  = 13;
    // j-type offset is 21 bits with implicit zero lsb
    localparam int unsigned J_IMM_W  = 21;

    // major opcodes that change control flow
    typedef enum logic [OPCODE_W-1:0] {
        OPCODE_OTHER  = 7'b0000000,
        OPCODE_BRANCH = 7'b1100011,
        OPCODE_JALR   = 7'b1100111,
        OPCODE_JAL    = 7'b1101111
    } opcode_e;

    // result of scanning one instruction word
    typedef enum logic [1:0] {
        CF_NONE,
        CF_BRANCH,
        CF_JAL,
        CF_JALR
    } cf_kind_e;

endpackage

// ==== src/frontend_pkg.sv ====
// ----------------------------
// fetch frontend types
// addresses, cache interface, prediction and fetch entries
// ----------------------------
package frontend_pkg;

    localparam int unsigned XLEN             = 32;
    localparam int unsigned FETCH_FIFO_DEPTH = 4;
    // credits count from 0 up to the full fifo depth
    localparam int unsigned CREDIT_W         = 3;
    localparam int unsigned FIFO_PTR_W       = $clog2(FETCH_FIFO_DEPTH);

    typedef logic [XLEN-1:0] addr_t;
    typedef logic [XLEN-1:0] instr_t;

    // ----------------------------
    // instruction cache interface
    // ----------------------------
    typedef struct packed {
        logic  req;
        logic  kill_s1;
        logic  kill_s2;
        addr_t vaddr;
    } icache_req_t;

    typedef struct packed {
        logic   ready;
        logic   valid;
        instr_t data;
        addr_t  vaddr;
    } icache_rsp_t;

    // branch resolved in the backend
    typedef struct packed {
        logic  valid;
        logic  is_mispredict;
        addr_t target;
    } resolved_branch_t;

    // static prediction fed back to pc generation
    typedef struct packed {
        logic  valid;
        addr_t target;
    } bp_t;

    // one entry toward decode
    typedef struct packed {
        addr_t  address;
        instr_t instr;
        logic   predict_taken;
        addr_t  predict_address;
    } fetch_entry_t;

endpackage

// ==== src/instr_scan.sv ====
// ----------------------------
// instruction scan
// classifies a word and builds its control-flow offset
// ----------------------------
module instr_scan (
    input  frontend_pkg::instr_t       instr_i,
    output riscv_isa_pkg::cf_kind_e    kind_o,
    output frontend_pkg::addr_t        imm_o
);
    import riscv_isa_pkg::*;
    import frontend_pkg::*;

    opcode_e              opcode;
    logic [B_IMM_W-1:0]   b_imm;
    logic [J_IMM_W-1:0]   j_imm;

    assign opcode = opcode_e'(instr_i[OPCODE_W-1:0]);

    // b-type: imm[12|10:5] in 31:25, imm[4:1|11] in 11:7
    assign b_imm = {instr_i[31], instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
    // j-type: imm[20|10:1|11|19:12] in 31:12
    assign j_imm = {instr_i[31], instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

    always_comb begin
        case (opcode)
            OPCODE_BRANCH: begin
                kind_o = CF_BRANCH;
                imm_o  = {{(XLEN-B_IMM_W){b_imm[B_IMM_W-1]}}, b_imm};
            end
            OPCODE_JAL: begin
                kind_o = CF_JAL;
                imm_o  = {{(XLEN-J_IMM_W){j_imm[J_IMM_W-1]}}, j_imm};
            end
            // target depends on a register, offset is of no use here
            OPCODE_JALR: begin
                kind_o = CF_JALR;
                imm_o  = '0;
            end
            default: begin
                kind_o = CF_NONE;
                imm_o  = '0;
            end
        endcase
    end

endmodule

// ==== src/pc_gen.sv ====
// ----------------------------
// pc generation
// next-pc priority, fetch credits and kill signals
// ----------------------------
module pc_gen (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  logic                            flush_i,
    input  frontend_pkg::addr_t             boot_addr_i,
    input  frontend_pkg::resolved_branch_t  resolved_branch_i,
    input  logic                            eret_i,
    input  frontend_pkg::addr_t             epc_i,
    input  logic                            ex_valid_i,
    input  frontend_pkg::addr_t             trap_vector_base_i,
    input  frontend_pkg::bp_t               bp_i,
    input  logic                            icache_ready_i,
    input  logic                            fifo_pop_i,
    output frontend_pkg::icache_req_t       icache_req_o
);
    import frontend_pkg::*;

    addr_t               npc_d, npc_q;
    addr_t               fetch_addr;
    // first cycle out of reset fetches from the boot address
    logic                rst_load_q;
    logic [CREDIT_W-1:0] credits_d, credits_q;
    logic                in_flight_q;
    logic                is_mispredict;
    logic                kill_s1, kill_s2;
    logic                credit_ok;
    logic                issue_req;
    logic                s2_eff_kill;

    // ----------------------------
    // kill signals
    // ----------------------------
    assign is_mispredict = resolved_branch_i.valid & resolved_branch_i.is_mispredict;
    assign kill_s1       = flush_i | is_mispredict;
    // a taken prediction drops the sequential word still in the cache
    assign kill_s2       = kill_s1 | bp_i.valid;

    // ----------------------------
    // next pc select
    // ----------------------------
    always_comb begin
        fetch_addr = rst_load_q ? boot_addr_i : npc_q;
        if (bp_i.valid) begin
            fetch_addr = bp_i.target;
        end
        // hold the address until the cache takes it
        npc_d = fetch_addr;
        if (issue_req) begin
            npc_d = fetch_addr + 'd4;
        end
        // redirects in rising priority, last one wins
        if (is_mispredict) begin
            npc_d = resolved_branch_i.target;
        end
        if (eret_i) begin
            npc_d = epc_i;
        end
        if (ex_valid_i) begin
            npc_d = trap_vector_base_i;
        end
    end

    // ----------------------------
    // credit flow control
    // ----------------------------
    assign credit_ok   = |credits_q;
    assign issue_req   = credit_ok & icache_ready_i & ~kill_s1;
    // response of last cycle's request is on the bus now
    assign s2_eff_kill = in_flight_q & kill_s2;

    assign credits_d = flush_i ? CREDIT_W'(FETCH_FIFO_DEPTH)
                     : credits_q + CREDIT_W'(fifo_pop_i) + CREDIT_W'(s2_eff_kill)
                       - CREDIT_W'(issue_req);

    assign icache_req_o = '{
        req:     credit_ok,
        kill_s1: kill_s1,
        kill_s2: kill_s2,
        vaddr:   fetch_addr
    };

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            npc_q       <= '0;
            rst_load_q  <= 1'b1;
            credits_q   <= CREDIT_W'(FETCH_FIFO_DEPTH);
            in_flight_q <= 1'b0;
        end else begin
            npc_q       <= npc_d;
            rst_load_q  <= 1'b0;
            credits_q   <= credits_d;
            in_flight_q <= issue_req;
        end
    end

    // credits returned by pops and kills never exceed what was handed out
    credits_bounded: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        credits_q <= CREDIT_W'(FETCH_FIFO_DEPTH)
    );

endmodule

// ==== src/branch_predict.sv ====
// ----------------------------
// response stage and static prediction
// registers the cache word and predicts its control flow
// ----------------------------
module branch_predict (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  frontend_pkg::icache_rsp_t    icache_rsp_i,
    input  logic                         kill_s2_i,
    output frontend_pkg::bp_t            bp_o,
    output frontend_pkg::fetch_entry_t   entry_o,
    output logic                         push_o
);
    import riscv_isa_pkg::*;
    import frontend_pkg::*;

    logic     rsp_take;
    logic     valid_q;
    instr_t   data_q;
    addr_t    vaddr_q;
    cf_kind_e kind;
    addr_t    imm;
    logic     taken;
    addr_t    target;

    // a response killed in flight never reaches the stage
    assign rsp_take = icache_rsp_i.valid & ~kill_s2_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= rsp_take;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rsp_take) begin
            data_q  <= icache_rsp_i.data;
            vaddr_q <= icache_rsp_i.vaddr;
        end
    end

    instr_scan i_instr_scan (
        .instr_i ( data_q ),
        .kind_o  ( kind   ),
        .imm_o   ( imm    )
    );

    // ----------------------------
    // static prediction
    // ----------------------------
    // jal always taken, branches only when jumping backward
    assign taken  = valid_q & ((kind == CF_JAL) | ((kind == CF_BRANCH) & imm[XLEN-1]));
    assign target = vaddr_q + imm;

    assign bp_o = '{
        valid:  taken,
        target: target
    };

    // every registered word goes to decode, taken or not
    assign push_o  = valid_q;
    assign entry_o = '{
        address:         vaddr_q,
        instr:           data_q,
        predict_taken:   taken,
        predict_address: target
    };

endmodule

// ==== src/fetch_fifo.sv ====
// ----------------------------
// fetch fifo
// flushable circular buffer of fetch entries
// ----------------------------
module fetch_fifo (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic                         flush_i,
    input  logic                         push_i,
    input  frontend_pkg::fetch_entry_t   data_i,
    input  logic                         pop_i,
    output frontend_pkg::fetch_entry_t   data_o,
    output logic                         empty_o
);
    import frontend_pkg::*;

    fetch_entry_t          mem_q [FETCH_FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] rd_ptr_q, wr_ptr_q;
    logic [CREDIT_W-1:0]   count_q;
    logic                  full;
    logic                  do_push, do_pop;

    assign full    = (count_q == CREDIT_W'(FETCH_FIFO_DEPTH));
    assign empty_o = (count_q == '0);
    // flush wins over both push and pop of the same cycle
    assign do_push = push_i & ~full & ~flush_i;
    assign do_pop  = pop_i & ~empty_o & ~flush_i;
    assign data_o  = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            // pointers wrap on their own, depth is a power of two
            rd_ptr_q <= rd_ptr_q + FIFO_PTR_W'(do_pop);
            wr_ptr_q <= wr_ptr_q + FIFO_PTR_W'(do_push);
            count_q  <= count_q + CREDIT_W'(do_push) - CREDIT_W'(do_pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    // request credits upstream keep the buffer from overflowing
    no_push_when_full: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (push_i && !flush_i) |-> !full
    );

    no_pop_when_empty: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        pop_i |-> !empty_o
    );

endmodule

// ==== src/frontend_top.sv ====
// ----------------------------
// instruction fetch frontend
// pc generation, static prediction and fetch fifo
// ----------------------------
module frontend_top (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  logic                            flush_i,
    input  frontend_pkg::addr_t             boot_addr_i,
    input  frontend_pkg::resolved_branch_t  resolved_branch_i,
    input  logic                            eret_i,
    input  frontend_pkg::addr_t             epc_i,
    input  logic                            ex_valid_i,
    input  frontend_pkg::addr_t             trap_vector_base_i,
    input  frontend_pkg::icache_rsp_t       icache_rsp_i,
    output frontend_pkg::icache_req_t       icache_req_o,
    output frontend_pkg::fetch_entry_t      fetch_entry_o,
    output logic                            fetch_entry_valid_o,
    input  logic                            fetch_ack_i
);
    import frontend_pkg::*;

    bp_t          bp;
    fetch_entry_t entry;
    logic         push;
    logic         fifo_empty;
    logic         fifo_pop;

    // decode takes an entry only when one is shown
    assign fetch_entry_valid_o = ~fifo_empty;
    assign fifo_pop            = fetch_ack_i & fetch_entry_valid_o;

    pc_gen i_pc_gen (
        .clk_i              ( clk_i              ),
        .rst_ni             ( rst_ni             ),
        .flush_i            ( flush_i            ),
        .boot_addr_i        ( boot_addr_i        ),
        .resolved_branch_i  ( resolved_branch_i  ),
        .eret_i             ( eret_i             ),
        .epc_i              ( epc_i              ),
        .ex_valid_i         ( ex_valid_i         ),
        .trap_vector_base_i ( trap_vector_base_i ),
        .bp_i               ( bp                 ),
        .icache_ready_i     ( icache_rsp_i.ready ),
        .fifo_pop_i         ( fifo_pop           ),
        .icache_req_o       ( icache_req_o       )
    );

    branch_predict i_branch_predict (
        .clk_i        ( clk_i                ),
        .rst_ni       ( rst_ni               ),
        .icache_rsp_i ( icache_rsp_i         ),
        .kill_s2_i    ( icache_req_o.kill_s2 ),
        .bp_o         ( bp                   ),
        .entry_o      ( entry                ),
        .push_o       ( push                 )
    );

    fetch_fifo i_fetch_fifo (
        .clk_i   ( clk_i         ),
        .rst_ni  ( rst_ni        ),
        .flush_i ( flush_i       ),
        .push_i  ( push          ),
        .data_i  ( entry         ),
        .pop_i   ( fifo_pop      ),
        .data_o  ( fetch_entry_o ),
        .empty_o ( fifo_empty    )
    );

endmodule

// ==== bench/clk_rst_gen.sv ====
// ----------------------------
// bench clock and reset
// 4 ns clock, active-low reset held for a fixed count of cycles
// ----------------------------
module clk_rst_gen #(
    parameter int unsigned RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_no
);
    timeunit 1ns;
    timeprecision 100ps;

    // 2 ns high, 2 ns low
    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    // release just after an edge, same as all other bench inputs
    initial begin
        rst_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1;
        rst_no = 1'b1;
    end

endmodule

// ==== bench/icache_model.sv ====
// ----------------------------
// instruction cache model
// random ready from the bench, response one cycle after accept
// ----------------------------
module icache_model (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       ready_i,
    input  frontend_pkg::icache_req_t  req_i,
    output frontend_pkg::icache_rsp_t  rsp_o,
    output frontend_pkg::addr_t        fetch_addr_o,
    input  frontend_pkg::instr_t       fetch_data_i
);
    timeunit 1ns;
    timeprecision 100ps;
    import frontend_pkg::*;

    logic  accept;
    logic  valid_q;
    addr_t addr_q;

    // a request killed in stage 1 never counts as accepted
    assign accept = req_i.req & ready_i & ~req_i.kill_s1;

    // single slot, so at most one response outstanding
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
            addr_q  <= '0;
        end else begin
            valid_q <= accept;
            if (accept) begin
                addr_q <= req_i.vaddr;
            end
        end
    end

    // word lookup is done by the bench from this address
    assign fetch_addr_o = addr_q;

    // kill_s2 is left to the frontend, the model always presents
    assign rsp_o = '{
        ready: ready_i,
        valid: valid_q,
        data:  fetch_data_i,
        vaddr: addr_q
    };

endmodule

// ==== include/tb_program.svh ====
// ----------------------------
// bench program and redirect table
// ----------------------------
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam frontend_pkg::addr_t  TB_BOOT_ADDR = 32'h8000_0000;
localparam frontend_pkg::instr_t TB_NOP       = 32'h0000_0013;

// beq x1, x0, offset
function automatic frontend_pkg::instr_t enc_branch(input int offset);
    logic [12:0]          imm;
    frontend_pkg::instr_t word;
    imm  = offset[12:0];
    word = {imm[12], imm[10:5], 13'd0, imm[4:1], imm[11], 7'd0};
    word[riscv_isa_pkg::RS1_LSB +: 5] = 5'd1;
    word[riscv_isa_pkg::OPCODE_W-1:0] = riscv_isa_pkg::OPCODE_BRANCH;
    return word;
endfunction

// jal x1, offset
function automatic frontend_pkg::instr_t enc_jal(input int offset);
    logic [20:0]          imm;
    frontend_pkg::instr_t word;
    imm  = offset[20:0];
    word = {imm[20], imm[10:1], imm[11], imm[19:12], 12'd0};
    word[riscv_isa_pkg::RD_LSB +: 5]  = 5'd1;
    word[riscv_isa_pkg::OPCODE_W-1:0] = riscv_isa_pkg::OPCODE_JAL;
    return word;
endfunction

// jalr x0, 0(x1)
function automatic frontend_pkg::instr_t enc_jalr();
    frontend_pkg::instr_t word;
    word = '0;
    word[riscv_isa_pkg::RS1_LSB +: 5] = 5'd1;
    word[riscv_isa_pkg::OPCODE_W-1:0] = riscv_isa_pkg::OPCODE_JALR;
    return word;
endfunction

// byte offset encoded at each branch or jal slot of the boot region
function automatic int program_offset(input frontend_pkg::addr_t addr);
    frontend_pkg::addr_t offs;
    offs = addr - TB_BOOT_ADDR;
    case (offs)
        32'd8:   return 16;
        32'd16:  return 8;
        32'd36:  return -36;
        default: return 0;
    endcase
endfunction

// predicted path 0 4 8 12 16 24 28 32 36 and back to 0
function automatic frontend_pkg::instr_t program_word(input frontend_pkg::addr_t addr);
    frontend_pkg::addr_t offs;
    offs = addr - TB_BOOT_ADDR;
    case (offs)
        32'd8:   return enc_branch(program_offset(addr));
        32'd16:  return enc_jal(program_offset(addr));
        32'd28:  return enc_jalr();
        32'd36:  return enc_branch(program_offset(addr));
        default: return TB_NOP;
    endcase
endfunction

typedef enum logic [1:0] {
    REDIR_MISPREDICT,
    REDIR_ERET,
    REDIR_TRAP,
    REDIR_ERET_TRAP
} redirect_e;

typedef struct packed {
    logic [7:0]          pops;
    redirect_e           kind;
    frontend_pkg::addr_t target;
    frontend_pkg::addr_t expect_addr;
} stim_row_t;

localparam int N_STIM = 5;

// eret together with trap expects the trap vector
localparam stim_row_t STIM_TABLE [N_STIM] = '{
    '{8'd12, REDIR_MISPREDICT, 32'h8000_0014, 32'h8000_0014},
    '{8'd10, REDIR_ERET,       32'h8000_0100, 32'h8000_0100},
    '{8'd8,  REDIR_TRAP,       32'h0000_1000, 32'h0000_1000},
    '{8'd6,  REDIR_ERET_TRAP,  32'h0000_2000, 32'h0000_2000},
    '{8'd16, REDIR_MISPREDICT, TB_BOOT_ADDR,  TB_BOOT_ADDR}
};

`endif

// ==== bench/tb_frontend.sv ====
// ----------------------------
// fetch frontend testbench
// table of redirects, reference path walker, random ready and ack
// ----------------------------
module tb_frontend;
    timeunit 1ns;
    timeprecision 100ps;
    import frontend_pkg::*;
    import riscv_isa_pkg::*;

`include "tb_program.svh"

    localparam int RESET_CYCLES     = 10;
    // entries checked after the last redirect of the table
    localparam int TAIL_POPS        = 8;
    localparam int CYCLES_PER_ENTRY = 64;

    logic             clk;
    logic             rst_n;
    logic             flush;
    addr_t            boot_addr;
    resolved_branch_t resolved_branch;
    logic             eret;
    addr_t            epc;
    logic             ex_valid;
    addr_t            trap_vector_base;
    icache_req_t      icache_req;
    icache_rsp_t      icache_rsp;
    fetch_entry_t     fetch_entry;
    logic             fetch_entry_valid;
    logic             fetch_ack;
    logic             cache_ready;
    addr_t            cache_addr;
    instr_t           cache_data;

    logic [15:0]      lfsr_state;
    // address the next popped entry must have
    addr_t            expect_addr;
    int               timeout_limit;
    int               cycle_count = 0;

    clk_rst_gen #(
        .RESET_CYCLES ( RESET_CYCLES )
    ) i_clk_rst_gen (
        .clk_o  ( clk   ),
        .rst_no ( rst_n )
    );

    icache_model i_icache_model (
        .clk_i        ( clk         ),
        .rst_ni       ( rst_n       ),
        .ready_i      ( cache_ready ),
        .req_i        ( icache_req  ),
        .rsp_o        ( icache_rsp  ),
        .fetch_addr_o ( cache_addr  ),
        .fetch_data_i ( cache_data  )
    );

    // memory contents come from the program function
    assign cache_data = program_word(cache_addr);

    frontend_top dut (
        .clk_i               ( clk               ),
        .rst_ni              ( rst_n             ),
        .flush_i             ( flush             ),
        .boot_addr_i         ( boot_addr         ),
        .resolved_branch_i   ( resolved_branch   ),
        .eret_i              ( eret              ),
        .epc_i               ( epc               ),
        .ex_valid_i          ( ex_valid          ),
        .trap_vector_base_i  ( trap_vector_base  ),
        .icache_rsp_i        ( icache_rsp        ),
        .icache_req_o        ( icache_req        ),
        .fetch_entry_o       ( fetch_entry       ),
        .fetch_entry_valid_o ( fetch_entry_valid ),
        .fetch_ack_i         ( fetch_ack         )
    );

    // ----------------------------
    // reporting
    // ----------------------------
    task automatic fail_run(input string line);
        $display("%s", line);
        $display("SIMULATION FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic report_error(input string msg);
        fail_run($sformatf("ERROR at %0t ns: %s", $time, msg));
    endtask

    // ----------------------------
    // random bits
    // ----------------------------
    // galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    // one step per bit taken
    task automatic take_bit(output logic b);
        b          = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
    endtask

    // ----------------------------
    // compare tasks
    // ----------------------------
    task automatic check_addr(input addr_t got, input addr_t exp, input string what);
        if (got !== exp) begin
            report_error($sformatf("%s is %h, expected %h", what, got, exp));
        end
    endtask

    task automatic verify_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_error($sformatf("%s is %b, expected %b", what, got, exp));
        end
    endtask

    // predicted target only matters when the entry is predicted taken
    task automatic check_entry(input fetch_entry_t got, input fetch_entry_t exp);
        check_addr(got.address, exp.address, "entry address");
        if (got.instr !== exp.instr) begin
            report_error($sformatf("instr at %h is %h, expected %h",
                                   exp.address, got.instr, exp.instr));
        end
        verify_flag(got.predict_taken, exp.predict_taken, "predict_taken");
        if (exp.predict_taken) begin
            check_addr(got.predict_address, exp.predict_address, "predicted target");
        end
    endtask

    // ----------------------------
    // reference walker
    // ----------------------------
    // jal always taken, conditional branch taken when offset is negative
    function automatic fetch_entry_t expected_entry(input addr_t pc);
        fetch_entry_t e;
        instr_t       w;
        int           offs;
        logic         taken;
        w     = program_word(pc);
        offs  = program_offset(pc);
        taken = (w[OPCODE_W-1:0] == OPCODE_JAL)
              || ((w[OPCODE_W-1:0] == OPCODE_BRANCH) && (offs < 0));
        e.address         = pc;
        e.instr           = w;
        e.predict_taken   = taken;
        e.predict_address = taken ? pc + addr_t'(offs) : pc + 32'd4;
        return e;
    endfunction

    // ready on about 3 of 4 cycles, ack on about half
    task automatic drive_random_inputs(output logic ack);
        logic r0;
        logic r1;
        take_bit(r0);
        take_bit(r1);
        cache_ready = r0 | r1;
        take_bit(ack);
    endtask

    // an entry shown with ack high is popped at the next edge
    task automatic pop_entries(input int n);
        int           popped;
        logic         ack;
        fetch_entry_t exp;
        popped = 0;
        while (popped < n) begin
            @(posedge clk);
            #1;
            drive_random_inputs(ack);
            fetch_ack = ack;
            if (ack && fetch_entry_valid) begin
                exp = expected_entry(expect_addr);
                check_entry(fetch_entry, exp);
                expect_addr = exp.predict_taken ? exp.predict_address
                                                : expect_addr + 32'd4;
                popped++;
            end
        end
    endtask

    // one cycle of redirect with flush, no ack in that cycle
    task automatic apply_redirect(input stim_row_t row);
        @(posedge clk);
        #1;
        fetch_ack = 1'b0;
        flush     = 1'b1;
        case (row.kind)
            REDIR_MISPREDICT: begin
                resolved_branch = '{valid: 1'b1, is_mispredict: 1'b1, target: row.target};
            end
            REDIR_ERET: begin
                eret = 1'b1;
                epc  = row.target;
            end
            REDIR_TRAP: begin
                ex_valid         = 1'b1;
                trap_vector_base = row.target;
            end
            REDIR_ERET_TRAP: begin
                // epc differs so a wrong winner shows up
                eret             = 1'b1;
                epc              = row.target + 32'h40;
                ex_valid         = 1'b1;
                trap_vector_base = row.target;
            end
        endcase
        @(posedge clk);
        #1;
        flush           = 1'b0;
        resolved_branch = '0;
        eret            = 1'b0;
        ex_valid        = 1'b0;
        verify_flag(fetch_entry_valid, 1'b0, "fetch_entry_valid after flush");
        expect_addr = row.expect_addr;
    endtask

    // ----------------------------
    // timeout
    // ----------------------------
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > timeout_limit) begin
            fail_run($sformatf("timeout: run did not finish within %0d clock cycles",
                               timeout_limit));
        end
    end

    // ----------------------------
    // main sequence
    // ----------------------------
    initial begin
        int total;
        flush            = 1'b0;
        boot_addr        = TB_BOOT_ADDR;
        resolved_branch  = '0;
        eret             = 1'b0;
        epc              = '0;
        ex_valid         = 1'b0;
        trap_vector_base = '0;
        fetch_ack        = 1'b0;
        cache_ready      = 1'b0;
        lfsr_state       = 16'd46;
        expect_addr      = TB_BOOT_ADDR;

        // limit grows with the number of entries to check
        total = TAIL_POPS;
        for (int i = 0; i < N_STIM; i++) begin
            total += int'(STIM_TABLE[i].pops);
        end
        timeout_limit = CYCLES_PER_ENTRY * total + RESET_CYCLES;

        @(posedge rst_n);
        @(negedge clk);
        // state right out of reset
        verify_flag(icache_req.req, 1'b1, "req after reset");
        verify_flag(icache_req.kill_s1, 1'b0, "kill_s1 after reset");
        verify_flag(icache_req.kill_s2, 1'b0, "kill_s2 after reset");
        verify_flag(fetch_entry_valid, 1'b0, "fetch_entry_valid after reset");
        check_addr(icache_req.vaddr, TB_BOOT_ADDR, "first request address");

        for (int i = 0; i < N_STIM; i++) begin
            pop_entries(int'(STIM_TABLE[i].pops));
            apply_redirect(STIM_TABLE[i]);
        end
        // entries after the final redirect
        pop_entries(TAIL_POPS);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== frontend_top.f ====
+incdir+include
src/riscv_isa_pkg.sv
src/frontend_pkg.sv
src/instr_scan.sv
src/pc_gen.sv
src/branch_predict.sv
src/fetch_fifo.sv
src/frontend_top.sv
bench/clk_rst_gen.sv
bench/icache_model.sv
bench/tb_frontend.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the fetch frontend testbench with verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module tb_frontend -Mdir obj_dir -f frontend_top.f; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_frontend 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx 'SIMULATION PASSED'; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1
